/* mips_control.f */
+incdir+bench
design/mips_control_pkg.sv
design/instr_decoder.sv
design/cycle_sequencer.sv
design/control_word_gen.sv
design/mips_control.sv
bench/tb_mips_control.sv

/* Bender.yml */
package:
  name: mips_control

sources:
  - design/mips_control_pkg.sv
  - design/instr_decoder.sv
  - design/cycle_sequencer.sv
  - design/control_word_gen.sv
  - design/mips_control.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_mips_control.sv

/* bench/tb_mips_control_table.svh */
// Row fields in order are name, opcode, funct, ovf, zero, period, reg_wr count, reg_dst,
// wb_sel, mem_wr count, execute pc_wr count, epc_wr count and cause
task automatic load_table;
    add_row("add", OP_RTYPE, FN_ADD, 0, 0, 5, 1, DST_RD, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("sub", OP_RTYPE, FN_SUB, 0, 0, 5, 1, DST_RD, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("and", OP_RTYPE, FN_AND, 0, 0, 5, 1, DST_RD, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("or", OP_RTYPE, FN_OR, 0, 0, 5, 1, DST_RD, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("slt", OP_RTYPE, FN_SLT, 0, 0, 5, 1, DST_RD, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("addi", OP_ADDI, 6'h00, 0, 0, 5, 1, DST_RT, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("andi", OP_ANDI, 6'h00, 0, 0, 5, 1, DST_RT, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("ori", OP_ORI, 6'h00, 0, 0, 5, 1, DST_RT, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("slti", OP_SLTI, 6'h00, 0, 0, 5, 1, DST_RT, WB_ALU_OUT, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("lw", OP_LW, 6'h00, 0, 0, 7, 1, DST_RT, WB_MDR, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("sw", OP_SW, 6'h00, 0, 0, 5, 0, DST_RT, '0, 1, 0, 0, CAUSE_OVERFLOW);
    add_row("beq_taken", OP_BEQ, 6'h00, 0, 1, 5, 0, DST_RT, '0, 0, 1, 0, CAUSE_OVERFLOW);
    add_row("beq_not", OP_BEQ, 6'h00, 0, 0, 5, 0, DST_RT, '0, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("bne_taken", OP_BNE, 6'h00, 0, 0, 5, 0, DST_RT, '0, 0, 1, 0, CAUSE_OVERFLOW);
    add_row("bne_not", OP_BNE, 6'h00, 0, 1, 5, 0, DST_RT, '0, 0, 0, 0, CAUSE_OVERFLOW);
    add_row("j", OP_J, 6'h00, 0, 0, 4, 0, DST_RT, '0, 0, 1, 0, CAUSE_OVERFLOW);
    add_row("jr", OP_RTYPE, FN_JR, 0, 0, 4, 0, DST_RT, '0, 0, 1, 0, CAUSE_OVERFLOW);
    add_row("jal", OP_JAL, 6'h00, 0, 0, 5, 1, DST_RA, WB_PC, 0, 1, 0, CAUSE_OVERFLOW);
    add_row("add_ovf", OP_RTYPE, FN_ADD, 1, 0, 6, 0, DST_RT, '0, 0, 0, 1, CAUSE_OVERFLOW);
    add_row("sub_ovf", OP_RTYPE, FN_SUB, 1, 0, 6, 0, DST_RT, '0, 0, 0, 1, CAUSE_OVERFLOW);
    add_row("addi_ovf", OP_ADDI, 6'h00, 1, 0, 6, 0, DST_RT, '0, 0, 0, 1, CAUSE_OVERFLOW);
    add_row("bad_opcode", 6'b111111, 6'h00, 0, 0, 4, 0, DST_RT, '0, 0, 0, 1, CAUSE_ILLEGAL);
    add_row("bad_funct", OP_RTYPE, 6'b111111, 0, 0, 4, 0, DST_RT, '0, 0, 0, 1, CAUSE_ILLEGAL);
endtask

/* bench/tb_mips_control.sv */
`timescale 1ns/1ps

module tb_mips_control
    import mips_control_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20;

    typedef struct {
        string    name;
        opcode_t  opcode;
        funct_t   funct;
        logic     ovf;
        logic     zero;
        int       period;
        int       reg_wr_n;
        dst_sel_t dst;
        wb_sel_t  wb;
        int       mem_wr_n;
        int       pc_wr_n;
        int       epc_n;
        cause_e   cause;
    } row_t;

    logic    clk;
    logic    reset;
    opcode_t opcode;
    funct_t  funct;
    logic    ovf;
    logic    zero;
    ctrl_t   ctrl;

    row_t rows[$];

    mips_control u_mips_control (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ovf    (ovf),
        .zero   (zero),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_row(input string name, input opcode_t op, input funct_t fn,
                           input logic ov, input logic zr, input int period,
                           input int reg_wr_n, input dst_sel_t dst, input wb_sel_t wb,
                           input int mem_wr_n, input int pc_wr_n, input int epc_n,
                           input cause_e cause);
        row_t r;
        r = '{name, op, fn, ov, zr, period, reg_wr_n, dst, wb, mem_wr_n, pc_wr_n, epc_n, cause};
        rows.push_back(r);
    endtask

    `include "tb_mips_control_table.svh"

    // Branches take the target, j and jal the jump address, jr the register
    function automatic pc_sel_t expected_pc_source(input opcode_t op);
        case (op)
            OP_BEQ, OP_BNE: return PC_BRANCH;
            OP_J, OP_JAL:   return PC_JUMP;
            default:        return PC_REG;
        endcase
    endfunction

    task automatic check_val(input string test, input string field, input int exp, input int act);
        assert (exp == act) else begin
            $display("ERR %s %s expected %0d actual %0d", test, field, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input row_t r);
        opcode = r.opcode;
        funct  = r.funct;
        ovf    = r.ovf;
        zero   = r.zero;
    endtask

    initial begin
        ctrl_t exp_word;
        row_t  r;
        int    cycles;
        bit    found;
        int    reg_n;
        int    mem_n;
        int    pc_n;
        int    epc_n;
        int    seen_dst;
        int    seen_wb;
        int    seen_pc_src;
        int    seen_cause;
        int    seen_vec;

        reset  = 1'b1;
        opcode = OP_RTYPE;
        funct  = FN_ADD;
        ovf    = 1'b0;
        zero   = 1'b0;
        load_table();

        repeat (4) begin
            @(negedge clk);
            check_val("reset", "ctrl", CTRL_IDLE, ctrl);
        end
        reset = 1'b0;
        #1;
        check_val("reset_release", "ctrl", CTRL_IDLE, ctrl);

        // First fetch in two steps
        @(negedge clk);
        exp_word            = CTRL_IDLE;
        exp_word.alu_src_a  = SRC_A_PC;
        exp_word.alu_src_b  = SRC_B_FOUR;
        exp_word.alu_op     = ALU_ADD;
        exp_word.alu_out_wr = 1'b1;
        check_val("fetch_step0", "ctrl", exp_word, ctrl);
        @(negedge clk);
        exp_word           = CTRL_IDLE;
        exp_word.ir_wr     = 1'b1;
        exp_word.pc_wr     = 1'b1;
        exp_word.pc_source = PC_ALU_RESULT;
        exp_word.iord      = ADDR_PC;
        check_val("fetch_step1", "ctrl", exp_word, ctrl);
        apply_row(rows[0]);

        for (int i = 0; i < rows.size(); i++) begin
            r           = rows[i];
            cycles      = 0;
            found       = 1'b0;
            reg_n       = 0;
            mem_n       = 0;
            pc_n        = 0;
            epc_n       = 0;
            seen_dst    = 0;
            seen_wb     = 0;
            seen_pc_src = 0;
            seen_cause  = 0;
            seen_vec    = 0;
            while (!found && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
                if (ctrl.ir_wr) begin
                    found = 1'b1;
                end else begin
                    if (ctrl.reg_wr) begin
                        reg_n++;
                        seen_dst = ctrl.reg_dst;
                        seen_wb  = ctrl.wb_sel;
                    end
                    if (ctrl.mem_wr)
                        mem_n++;
                    if (ctrl.epc_wr) begin
                        epc_n++;
                        seen_cause = ctrl.cause;
                        seen_vec   = (ctrl.pc_source == PC_VECTOR) && ctrl.pc_wr;
                    end else if (ctrl.pc_wr) begin
                        pc_n++;
                        seen_pc_src = ctrl.pc_source;
                    end
                end
            end
            if (!found) begin
                $display("Timed out waiting for the next instruction fetch after %s", r.name);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end

            check_val(r.name, "period", r.period, cycles);
            check_val(r.name, "reg_wr count", r.reg_wr_n, reg_n);
            if (r.reg_wr_n > 0) begin
                check_val(r.name, "reg_dst", r.dst, seen_dst);
                check_val(r.name, "wb_sel", r.wb, seen_wb);
            end
            check_val(r.name, "mem_wr count", r.mem_wr_n, mem_n);
            check_val(r.name, "pc_wr count", r.pc_wr_n, pc_n);
            // Execute-phase PC source per instruction
            if (pc_n > 0)
                check_val(r.name, "pc_source", expected_pc_source(r.opcode), seen_pc_src);
            check_val(r.name, "epc_wr count", r.epc_n, epc_n);
            if (r.epc_n > 0) begin
                check_val(r.name, "cause", r.cause, seen_cause);
                check_val(r.name, "vector pc_wr", 1, seen_vec);
            end

            if (i + 1 < rows.size())
                apply_row(rows[i + 1]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* design/mips_control.sv */
`timescale 1ns/1ps

module mips_control
    import mips_control_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    input  funct_t  funct,
    input  logic    ovf,
    input  logic    zero,
    output ctrl_t   ctrl
);

    instr_e instr_class;
    instr_e exec_class;
    phase_e phase;
    step_t  step;
    logic   abort;

    instr_decoder u_instr_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    cycle_sequencer u_cycle_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ovf         (ovf),
        .phase       (phase),
        .exec_class  (exec_class),
        .step        (step),
        .abort       (abort)
    );

    control_word_gen u_control_word_gen (
        .phase      (phase),
        .exec_class (exec_class),
        .step       (step),
        .abort      (abort),
        .zero       (zero),
        .ctrl       (ctrl)
    );

endmodule

/* design/control_word_gen.sv */
`timescale 1ns/1ps

module control_word_gen
    import mips_control_pkg::*;
(
    input  phase_e phase,
    input  instr_e exec_class,
    input  step_t  step,
    input  logic   abort,
    input  logic   zero,
    output ctrl_t  ctrl
);

    function automatic logic is_imm_alu(input instr_e cls);
        return (cls == I_ADDI) || (cls == I_ANDI) || (cls == I_ORI) || (cls == I_SLTI);
    endfunction

    function automatic alu_op_e alu_op_of(input instr_e cls);
        case (cls)
            I_ADD, I_ADDI: return ALU_ADD;
            I_SUB:         return ALU_SUB;
            I_AND, I_ANDI: return ALU_AND;
            I_OR, I_ORI:   return ALU_OR;
            I_SLT, I_SLTI: return ALU_SLT;
            default:       return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        ctrl = CTRL_IDLE;
        case (phase)
            PH_FETCH: begin
                if (step == step_t'(0)) begin
                    // ALUOut = PC + 4
                    ctrl.alu_src_a  = SRC_A_PC;
                    ctrl.alu_src_b  = SRC_B_FOUR;
                    ctrl.alu_op     = ALU_ADD;
                    ctrl.alu_out_wr = 1'b1;
                end else begin
                    ctrl.iord      = ADDR_PC;
                    ctrl.ir_wr     = 1'b1;
                    ctrl.pc_source = PC_ALU_RESULT;
                    ctrl.pc_wr     = 1'b1;
                end
            end
            PH_DECODE: begin
                // Register read plus branch target into ALUOut
                ctrl.wr_a       = 1'b1;
                ctrl.wr_b       = 1'b1;
                ctrl.alu_src_a  = SRC_A_PC;
                ctrl.alu_src_b  = SRC_B_IMM_SHIFT;
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_out_wr = 1'b1;
            end
            PH_EXEC: begin
                case (exec_class)
                    I_ADD, I_SUB, I_AND, I_OR, I_SLT,
                    I_ADDI, I_ANDI, I_ORI, I_SLTI: begin
                        if (step == step_t'(0)) begin
                            ctrl.alu_src_a  = SRC_A_REG;
                            ctrl.alu_src_b  = is_imm_alu(exec_class) ? SRC_B_IMM : SRC_B_REG;
                            ctrl.alu_op     = alu_op_of(exec_class);
                            ctrl.alu_out_wr = 1'b1;
                        end else if (!abort) begin
                            ctrl.reg_wr  = 1'b1;
                            ctrl.wb_sel  = WB_ALU_OUT;
                            ctrl.reg_dst = is_imm_alu(exec_class) ? DST_RT : DST_RD;
                        end
                    end
                    I_LW, I_SW: begin
                        if (step == step_t'(0)) begin
                            // Effective address
                            ctrl.alu_src_a  = SRC_A_REG;
                            ctrl.alu_src_b  = SRC_B_IMM;
                            ctrl.alu_op     = ALU_ADD;
                            ctrl.alu_out_wr = 1'b1;
                        end else if (step == step_t'(1)) begin
                            ctrl.iord   = ADDR_ALU_OUT;
                            ctrl.mem_wr = (exec_class == I_SW);
                        end else if (step == step_t'(3)) begin
                            ctrl.reg_wr  = 1'b1;
                            ctrl.wb_sel  = WB_MDR;
                            ctrl.reg_dst = DST_RT;
                        end
                    end
                    I_BEQ, I_BNE: begin
                        // ALUOut keeps the branch target from decode
                        if (step == step_t'(0)) begin
                            ctrl.alu_src_a = SRC_A_REG;
                            ctrl.alu_src_b = SRC_B_REG;
                            ctrl.alu_op    = ALU_SUB;
                        end else if (zero == (exec_class == I_BEQ)) begin
                            ctrl.pc_source = PC_BRANCH;
                            ctrl.pc_wr     = 1'b1;
                        end
                    end
                    I_J: begin
                        ctrl.pc_source = PC_JUMP;
                        ctrl.pc_wr     = 1'b1;
                    end
                    I_JR: begin
                        ctrl.pc_source = PC_REG;
                        ctrl.pc_wr     = 1'b1;
                    end
                    I_JAL: begin
                        if (step == step_t'(0)) begin
                            // Link before PC moves
                            ctrl.reg_wr  = 1'b1;
                            ctrl.wb_sel  = WB_PC;
                            ctrl.reg_dst = DST_RA;
                        end else begin
                            ctrl.pc_source = PC_JUMP;
                            ctrl.pc_wr     = 1'b1;
                        end
                    end
                    default: begin
                        ctrl = CTRL_IDLE;
                    end
                endcase
            end
            PH_EXCEPT: begin
                ctrl.epc_wr    = 1'b1;
                ctrl.cause     = (exec_class == I_ILLEGAL) ? CAUSE_ILLEGAL : CAUSE_OVERFLOW;
                ctrl.pc_source = PC_VECTOR;
                ctrl.pc_wr     = 1'b1;
            end
            default: begin
                ctrl = CTRL_IDLE;
            end
        endcase
    end

endmodule

/* design/cycle_sequencer.sv */
`timescale 1ns/1ps

module cycle_sequencer
    import mips_control_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  instr_e instr_class,
    input  logic   ovf,
    output phase_e phase,
    output instr_e exec_class,
    output step_t  step,
    output logic   abort
);

    // Number of execute cycles per class
    function automatic step_t last_step(input instr_e cls);
        int len;
        case (cls)
            I_LW:       len = MAX_STEPS;
            I_J, I_JR:  len = 1;
            default:    len = 2;
        endcase
        return step_t'(len - 1);
    endfunction

    function automatic logic ovf_checked(input instr_e cls);
        return (cls == I_ADD) || (cls == I_SUB) || (cls == I_ADDI);
    endfunction

    // Overflow shows up while the result is being written back
    assign abort = (phase == PH_EXEC) && (step == step_t'(1)) &&
                   ovf_checked(exec_class) && ovf;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= PH_RESET;
            step       <= '0;
            exec_class <= I_ADD;
        end else begin
            case (phase)
                PH_RESET: begin
                    phase <= PH_FETCH;
                    step  <= '0;
                end
                PH_FETCH: begin
                    if (step == step_t'(1)) begin
                        phase <= PH_DECODE;
                        step  <= '0;
                    end else begin
                        step <= step + step_t'(1);
                    end
                end
                PH_DECODE: begin
                    exec_class <= instr_class;
                    step       <= '0;
                    if (instr_class == I_ILLEGAL) begin
                        phase <= PH_EXCEPT;
                    end else begin
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC: begin
                    if (abort) begin
                        phase <= PH_EXCEPT;
                        step  <= '0;
                    end else if (step == last_step(exec_class)) begin
                        phase <= PH_FETCH;
                        step  <= '0;
                    end else begin
                        step <= step + step_t'(1);
                    end
                end
                PH_EXCEPT: begin
                    phase <= PH_FETCH;
                    step  <= '0;
                end
                default: begin
                    phase <= PH_RESET;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import mips_control_pkg::*;
(
    input  opcode_t opcode,
    input  funct_t  funct,
    output instr_e  instr_class
);

    always_comb begin
        instr_class = I_ILLEGAL;
        case (opcode)
            OP_RTYPE: begin
                // Funct only matters for R-type
                case (funct)
                    FN_ADD:  instr_class = I_ADD;
                    FN_SUB:  instr_class = I_SUB;
                    FN_AND:  instr_class = I_AND;
                    FN_OR:   instr_class = I_OR;
                    FN_SLT:  instr_class = I_SLT;
                    FN_JR:   instr_class = I_JR;
                    default: instr_class = I_ILLEGAL;
                endcase
            end
            OP_LW:   instr_class = I_LW;
            OP_SW:   instr_class = I_SW;
            OP_ADDI: instr_class = I_ADDI;
            OP_ANDI: instr_class = I_ANDI;
            OP_ORI:  instr_class = I_ORI;
            OP_SLTI: instr_class = I_SLTI;
            OP_BEQ:  instr_class = I_BEQ;
            OP_BNE:  instr_class = I_BNE;
            OP_J:    instr_class = I_J;
            OP_JAL:  instr_class = I_JAL;
            default: instr_class = I_ILLEGAL;
        endcase
    end

endmodule

/* design/mips_control_pkg.sv */
package mips_control_pkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;

    // R-type funct codes
    localparam funct_t FN_ADD = 6'b100000;
    localparam funct_t FN_SUB = 6'b100010;
    localparam funct_t FN_AND = 6'b100100;
    localparam funct_t FN_OR  = 6'b100101;
    localparam funct_t FN_SLT = 6'b101010;
    localparam funct_t FN_JR  = 6'b001000;

    typedef enum logic [4:0] {
        I_ADD,
        I_SUB,
        I_AND,
        I_OR,
        I_SLT,
        I_JR,
        I_LW,
        I_SW,
        I_ADDI,
        I_ANDI,
        I_ORI,
        I_SLTI,
        I_BEQ,
        I_BNE,
        I_J,
        I_JAL,
        I_ILLEGAL
    } instr_e;

    typedef enum logic [2:0] {
        PH_RESET,
        PH_FETCH,
        PH_DECODE,
        PH_EXEC,
        PH_EXCEPT
    } phase_e;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        CAUSE_OVERFLOW = 2'd0,
        CAUSE_ILLEGAL  = 2'd2
    } cause_e;

    // Execute step counter sized for lw
    typedef logic [2:0] step_t;
    localparam int MAX_STEPS = 4;

    // Datapath mux selects
    typedef logic [2:0] addr_sel_t;
    localparam addr_sel_t ADDR_PC      = 3'd0;
    localparam addr_sel_t ADDR_ALU_OUT = 3'd4;

    typedef logic [2:0] wb_sel_t;
    localparam wb_sel_t WB_MDR     = 3'd2;
    localparam wb_sel_t WB_ALU_OUT = 3'd3;
    localparam wb_sel_t WB_PC      = 3'd6;

    typedef logic [1:0] dst_sel_t;
    localparam dst_sel_t DST_RT = 2'd0;
    localparam dst_sel_t DST_RD = 2'd1;
    localparam dst_sel_t DST_RA = 2'd2;

    typedef logic [1:0] src_a_t;
    localparam src_a_t SRC_A_PC  = 2'd0;
    localparam src_a_t SRC_A_REG = 2'd2;

    typedef logic [2:0] src_b_t;
    localparam src_b_t SRC_B_REG       = 3'd0;
    localparam src_b_t SRC_B_FOUR      = 3'd1;
    localparam src_b_t SRC_B_IMM       = 3'd2;
    localparam src_b_t SRC_B_IMM_SHIFT = 3'd3;

    typedef logic [2:0] pc_sel_t;
    localparam pc_sel_t PC_ALU_RESULT = 3'd0;
    localparam pc_sel_t PC_BRANCH     = 3'd1;
    localparam pc_sel_t PC_REG        = 3'd2;
    localparam pc_sel_t PC_JUMP       = 3'd3;
    localparam pc_sel_t PC_VECTOR     = 3'd4;

    // One cycle of datapath control
    typedef struct packed {
        addr_sel_t iord;
        logic      mem_wr;
        logic      ir_wr;
        logic      reg_wr;
        logic      wr_a;
        logic      wr_b;
        wb_sel_t   wb_sel;
        dst_sel_t  reg_dst;
        src_a_t    alu_src_a;
        src_b_t    alu_src_b;
        alu_op_e   alu_op;
        logic      alu_out_wr;
        pc_sel_t   pc_source;
        logic      pc_wr;
        logic      epc_wr;
        cause_e    cause;
    } ctrl_t;

    localparam ctrl_t CTRL_IDLE = '0;

endpackage
